// File: alu/cpu_alu.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpu_alu (
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic                  exec,
    input  cpu_pkg::instr_u       instr,
    input  logic [`CPU_XLEN-1:0]  ra_value,
    input  logic [`CPU_XLEN-1:0]  rb_value,
    output logic [`CPU_XLEN-1:0]  result
);
    cpu_pkg::opcode_e      op;
    logic [`CPU_XLEN-1:0]  imm_sext;
    logic [`CPU_XLEN-1:0]  imm_upper;
    logic [`CPU_XLEN-1:0]  add_b;
    logic [`CPU_XLEN-1:0]  sum;
    logic [`CPU_XLEN-1:0]  alu_out;
    logic                  subtract;
    logic                  use_imm;

    assign op = instr.i.opcode;

    assign imm_sext  = {{(`CPU_XLEN-16){instr.i.imm16[15]}}, instr.i.imm16};
    assign imm_upper = {instr.i.imm16, {(`CPU_XLEN-16){1'b0}}};

    // ADD, SUB and ADDI share one adder
    always_comb begin
        subtract = 1'b0;
        use_imm  = 1'b0;
        case (op)
            cpu_pkg::SUB:  subtract = 1'b1;
            cpu_pkg::ADDI: use_imm  = 1'b1;
            default: begin
                subtract = 1'b0;
                use_imm  = 1'b0;
            end
        endcase
    end

    assign add_b = use_imm ? imm_sext : rb_value;

    // Two's complement subtract as invert plus carry in
    assign sum = ra_value + (subtract ? ~add_b : add_b) + subtract;

    always_comb begin
        case (op)
            cpu_pkg::ADD,
            cpu_pkg::SUB,
            cpu_pkg::ADDI: alu_out = sum;
            cpu_pkg::AND:  alu_out = ra_value & rb_value;
            cpu_pkg::OR:   alu_out = ra_value | rb_value;
            cpu_pkg::XOR:  alu_out = ra_value ^ rb_value;
            cpu_pkg::LUI:  alu_out = imm_upper;
            default:       alu_out = '0;
        endcase
    end

    // Held from EXEC into COMMIT
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
        end else if (exec) begin
            result <= alu_out;
        end
    end

endmodule

// File: common/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Data path and address width, memory is word addressed
`define CPU_XLEN 32

// General register file
`define CPU_NREGS 8
`define CPU_REG_BITS 3

// First instruction fetch after reset
`define CPU_RESET_PC 0

`endif

// File: common/cpu_pkg.sv
`include "cpu_defines.svh"

package cpu_pkg;

    // Bits 6 to 0 of every instruction word
    typedef enum logic [6:0] {
        ADD  = 7'd1,
        SUB  = 7'd2,
        AND  = 7'd3,
        OR   = 7'd4,
        XOR  = 7'd5,
        ADDI = 7'd6,
        ST   = 7'd7,
        LD   = 7'd8,
        LUI  = 7'd9,
        BZ   = 7'd10,
        HALT = 7'd127
    } opcode_e;

    // Register format
    typedef struct packed {
        logic [15:0]               unused;
        logic [`CPU_REG_BITS-1:0]  rb;
        logic [`CPU_REG_BITS-1:0]  ra;
        logic [`CPU_REG_BITS-1:0]  rd;
        opcode_e                   opcode;
    } instr_r_t;

    // Immediate format, ra sits in the same bits as in the register format
    typedef struct packed {
        logic [15:0]               imm16;
        logic [2:0]                unused;
        logic [`CPU_REG_BITS-1:0]  ra;
        logic [`CPU_REG_BITS-1:0]  rd;
        opcode_e                   opcode;
    } instr_i_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

    typedef struct packed {
        logic [`CPU_XLEN-1:0] address;
        logic [`CPU_XLEN-1:0] wdata;
        logic                 write;
    } mem_req_t;

    typedef struct packed {
        logic                      en;
        logic [`CPU_REG_BITS-1:0]  idx;
        logic [`CPU_XLEN-1:0]      value;
    } reg_wr_t;

    typedef enum logic [1:0] {
        FETCH  = 2'd0,
        EXEC   = 2'd1,
        COMMIT = 2'd2,
        HALTED = 2'd3
    } phase_e;

endpackage

// File: design/cpu_regfile.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpu_regfile (
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic [`CPU_REG_BITS-1:0]  ra_idx,
    input  logic [`CPU_REG_BITS-1:0]  rb_idx,
    input  cpu_pkg::reg_wr_t          wr,
    output logic [`CPU_XLEN-1:0]      ra_value,
    output logic [`CPU_XLEN-1:0]      rb_value,
    output logic                      ra_flag
);
    logic [`CPU_XLEN-1:0]   regs [`CPU_NREGS];
    logic [`CPU_NREGS-1:0]  zero_flags;
    logic                   wr_zero;

    // Flag follows the value being written, not the old contents
    assign wr_zero = (wr.value == '0);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CPU_NREGS; i++) begin
                regs[i] <= '0;
            end
            zero_flags <= '1;
        end else if (wr.en) begin
            regs[wr.idx]       <= wr.value;
            zero_flags[wr.idx] <= wr_zero;
        end
    end

    // Combinational reads on the latched instruction indices
    assign ra_value = regs[ra_idx];
    assign rb_value = regs[rb_idx];
    assign ra_flag  = zero_flags[ra_idx];

endmodule

// File: design/cpu_sequencer.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpu_sequencer (
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic [`CPU_XLEN-1:0]      data,
    input  logic [`CPU_XLEN-1:0]      ra_value,
    input  logic [`CPU_XLEN-1:0]      rb_value,
    input  logic                      ra_flag,
    input  logic [`CPU_XLEN-1:0]      result,
    output cpu_pkg::instr_u           instr,
    output logic                      exec,
    output logic [`CPU_REG_BITS-1:0]  ra_idx,
    output logic [`CPU_REG_BITS-1:0]  rb_idx,
    output cpu_pkg::reg_wr_t          wr,
    output cpu_pkg::mem_req_t         mem_req,
    output logic                      halted
);
    cpu_pkg::phase_e       phase;
    cpu_pkg::instr_u       ir;
    cpu_pkg::opcode_e      op;
    logic [`CPU_XLEN-1:0]  pc;
    logic [`CPU_XLEN-1:0]  pc_next;
    logic [`CPU_XLEN-1:0]  branch_target;
    logic                  commit;
    logic                  alu_op;
    logic                  take_branch;

    assign op     = ir.r.opcode;
    assign commit = (phase == cpu_pkg::COMMIT);
    assign exec   = (phase == cpu_pkg::EXEC);
    assign halted = (phase == cpu_pkg::HALTED);

    assign instr  = ir;
    assign ra_idx = ir.r.ra;
    assign rb_idx = ir.r.rb;

    // Opcodes whose registered ALU result goes back to rd
    always_comb begin
        case (op)
            cpu_pkg::ADD,
            cpu_pkg::SUB,
            cpu_pkg::AND,
            cpu_pkg::OR,
            cpu_pkg::XOR,
            cpu_pkg::ADDI,
            cpu_pkg::LUI: alu_op = 1'b1;
            default:      alu_op = 1'b0;
        endcase
    end

    // Branch target is an absolute word address
    assign branch_target = {{(`CPU_XLEN-16){1'b0}}, ir.i.imm16};
    assign take_branch   = (op == cpu_pkg::BZ) && ra_flag;
    assign pc_next       = take_branch ? branch_target : pc + 1'b1;

    // Fetch uses pc, commit redirects the port for LD and ST
    always_comb begin
        mem_req.address = pc;
        mem_req.wdata   = ra_value;
        mem_req.write   = 1'b0;
        if (commit) begin
            if (op == cpu_pkg::LD) begin
                mem_req.address = ra_value;
            end else if (op == cpu_pkg::ST) begin
                mem_req.address = rb_value;
                mem_req.write   = 1'b1;
            end
        end
    end

    always_comb begin
        wr.en    = commit && (alu_op || (op == cpu_pkg::LD));
        wr.idx   = ir.r.rd;
        wr.value = (op == cpu_pkg::LD) ? data : result;
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            phase <= cpu_pkg::FETCH;
            pc    <= `CPU_RESET_PC;
            ir    <= '0;
        end else begin
            case (phase)
                cpu_pkg::FETCH: begin
                    ir    <= data;
                    phase <= cpu_pkg::EXEC;
                end
                cpu_pkg::EXEC: begin
                    phase <= cpu_pkg::COMMIT;
                end
                cpu_pkg::COMMIT: begin
                    if (op == cpu_pkg::HALT) begin
                        phase <= cpu_pkg::HALTED;
                    end else begin
                        pc    <= pc_next;
                        phase <= cpu_pkg::FETCH;
                    end
                end
                // Stays here until the next reset
                default: begin
                    phase <= cpu_pkg::HALTED;
                end
            endcase
        end
    end

endmodule

// File: design/cpu_top.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpu_top (
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic [`CPU_XLEN-1:0] data,
    output cpu_pkg::mem_req_t    mem_req,
    output logic                 halted
);
    cpu_pkg::instr_u           instr;
    cpu_pkg::reg_wr_t          wr;
    logic                      exec;
    logic [`CPU_REG_BITS-1:0]  ra_idx;
    logic [`CPU_REG_BITS-1:0]  rb_idx;
    logic [`CPU_XLEN-1:0]      ra_value;
    logic [`CPU_XLEN-1:0]      rb_value;
    logic                      ra_flag;
    logic [`CPU_XLEN-1:0]      result;

    cpu_sequencer u_sequencer (
        .clock    (clock),
        .rst_n    (rst_n),
        .data     (data),
        .ra_value (ra_value),
        .rb_value (rb_value),
        .ra_flag  (ra_flag),
        .result   (result),
        .instr    (instr),
        .exec     (exec),
        .ra_idx   (ra_idx),
        .rb_idx   (rb_idx),
        .wr       (wr),
        .mem_req  (mem_req),
        .halted   (halted)
    );

    cpu_regfile u_regfile (
        .clock    (clock),
        .rst_n    (rst_n),
        .ra_idx   (ra_idx),
        .rb_idx   (rb_idx),
        .wr       (wr),
        .ra_value (ra_value),
        .rb_value (rb_value),
        .ra_flag  (ra_flag)
    );

    cpu_alu u_alu (
        .clock    (clock),
        .rst_n    (rst_n),
        .exec     (exec),
        .instr    (instr),
        .ra_value (ra_value),
        .rb_value (rb_value),
        .result   (result)
    );

endmodule

// File: sources.f
+incdir+common
+incdir+testbench
common/cpu_pkg.sv
alu/cpu_alu.sv
design/cpu_regfile.sv
design/cpu_sequencer.sv
design/cpu_top.sv
testbench/tb_cpu.sv

// File: testbench/tb_cpu_ref.svh
`ifndef TB_CPU_REF_SVH
`define TB_CPU_REF_SVH

// Expected store stream from the ISA model, in program order
logic [31:0] exp_addr [$];
logic [31:0] exp_data [$];

function automatic logic [31:0] enc_r(input logic [6:0] op, input int rd, input int ra,
                                      input int rb);
    return {16'h0000, rb[2:0], ra[2:0], rd[2:0], op};
endfunction

function automatic logic [31:0] enc_i(input logic [6:0] op, input int rd, input int ra,
                                      input logic [15:0] imm);
    return {imm, 3'b000, ra[2:0], rd[2:0], op};
endfunction

// Runs the image in img and returns the executed instruction count, or -1 without HALT
function automatic int run_reference();
    logic [31:0] rmem [256];
    logic [31:0] regs [8];
    logic [7:0]  zflag;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] wval;
    logic [31:0] pc;
    logic [31:0] pc_next;
    logic        wen;
    int          steps;
    exp_addr.delete();
    exp_data.delete();
    for (int i = 0; i < 256; i++) begin
        rmem[i] = img[i];
    end
    for (int i = 0; i < 8; i++) begin
        regs[i] = '0;
    end
    zflag = '1;
    pc = `CPU_RESET_PC;
    steps = 0;
    while (steps < 2000) begin
        w = rmem[pc[7:0]];
        a = regs[w[12:10]];
        b = regs[w[15:13]];
        wen = 1'b1;
        wval = '0;
        pc_next = pc + 1;
        steps++;
        case (w[6:0])
            cpu_pkg::ADD:  wval = a + b;
            cpu_pkg::SUB:  wval = a - b;
            cpu_pkg::AND:  wval = a & b;
            cpu_pkg::OR:   wval = a | b;
            cpu_pkg::XOR:  wval = a ^ b;
            cpu_pkg::ADDI: wval = a + {{16{w[31]}}, w[31:16]};
            cpu_pkg::LUI:  wval = {w[31:16], 16'h0000};
            cpu_pkg::LD:   wval = rmem[a[7:0]];
            cpu_pkg::ST: begin
                wen = 1'b0;
                exp_addr.push_back(b);
                exp_data.push_back(a);
                rmem[b[7:0]] = a;
            end
            cpu_pkg::BZ: begin
                wen = 1'b0;
                if (zflag[w[12:10]]) begin
                    pc_next = {16'h0000, w[31:16]};
                end
            end
            cpu_pkg::HALT: return steps;
            default:       wen = 1'b0;
        endcase
        if (wen) begin
            regs[w[9:7]] = wval;
            zflag[w[9:7]] = (wval == '0);
        end
        pc = pc_next;
    end
    return -1;
endfunction

`endif

// File: testbench/tb_cpu.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module tb_cpu;

    logic                  clock;
    logic                  rst_n;
    logic [`CPU_XLEN-1:0]  data;
    cpu_pkg::mem_req_t     mem_req;
    logic                  halted;

    logic [31:0]  mem [256];
    logic [31:0]  img [256];
    int           prog_len;
    string        test_name;
    int           store_count;
    int           cycle_count = 0;
    int           cycle_limit = 200;
    logic [31:0]  seen_addr;
    logic [31:0]  seen_data;

    `include "tb_cpu_ref.svh"

    cpu_top i_dut (
        .clock   (clock),
        .rst_n   (rst_n),
        .data    (data),
        .mem_req (mem_req),
        .halted  (halted)
    );

    always #5 clock = ~clock;

    // Reads answer in the same cycle, stores land at the closing edge
    assign data = mem[mem_req.address[7:0]];

    always @(posedge clock) begin
        if (rst_n && mem_req.write) begin
            mem[mem_req.address[7:0]] <= mem_req.wdata;
        end
    end

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Error: %s expected %h actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    // Each store cycle is compared in order against the ISA model
    always @(posedge clock) begin
        if (rst_n && mem_req.write) begin
            seen_addr = mem_req.address;
            seen_data = mem_req.wdata;
            #1;
            if (store_count >= exp_addr.size()) begin
                $display("Test %s made an extra store to address %h", test_name, seen_addr);
                abort_run();
            end else begin
                check_value({test_name, " store address"}, exp_addr[store_count], seen_addr);
                check_value({test_name, " store data"}, exp_data[store_count], seen_data);
                store_count++;
            end
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Run took more than %0d cycles in test %s", cycle_limit, test_name);
            abort_run();
        end
    end

    task automatic start_program();
        prog_len = 0;
        for (int i = 0; i < 256; i++) begin
            img[i] = {i[7:0], 16'hd00d, ~i[7:0]};
        end
    endtask

    task automatic emit(input logic [31:0] word);
        img[prog_len] = word;
        prog_len++;
    endtask

    // Upper half absorbs the sign of the low half that ADDI extends
    task automatic emit_const(input int rd, input logic [31:0] value);
        logic [31:0] upper;
        upper = value - {{16{value[15]}}, value[15:0]};
        emit(enc_i(cpu_pkg::LUI, rd, 0, upper[31:16]));
        emit(enc_i(cpu_pkg::ADDI, rd, rd, value[15:0]));
    endtask

    // r7 is the store pointer
    task automatic emit_store_next(input int rs);
        emit(enc_r(cpu_pkg::ST, 0, rs, 7));
        emit(enc_i(cpu_pkg::ADDI, 7, 7, 16'd1));
    endtask

    task automatic run_test(input string name);
        int n;
        int edges;
        n = run_reference();
        test_name = name;
        if (n < 0) begin
            $display("Program of test %s never reaches HALT in the ISA model", name);
            abort_run();
        end
        cycle_limit += 4 * 3 * n;
        @(posedge clock);
        #1;
        rst_n = 1'b0;
        store_count = 0;
        for (int i = 0; i < 256; i++) begin
            mem[i] <= img[i];
        end
        repeat (2) begin
            @(posedge clock);
            #1;
            check_value({name, " reset write"}, 0, mem_req.write);
            check_value({name, " reset halted"}, 0, halted);
            check_value({name, " reset address"}, 0, mem_req.address);
        end
        rst_n = 1'b1;
        check_value({name, " first fetch address"}, 0, mem_req.address);
        check_value({name, " first fetch data"}, img[0], data);
        edges = 0;
        while (!halted) begin
            @(posedge clock);
            #1;
            edges++;
        end
        check_value({name, " halt cycle"}, 3 * n, edges);
        check_value({name, " store count"}, exp_addr.size(), store_count);
        repeat (20) begin
            @(posedge clock);
            #1;
            check_value({name, " write after halt"}, 0, mem_req.write);
            check_value({name, " halted held"}, 1, halted);
        end
    endtask

    task automatic build_regreg_program();
        logic [6:0] ops [5];
        int ra;
        int rb;
        int rd;
        ops = '{cpu_pkg::ADD, cpu_pkg::SUB, cpu_pkg::AND, cpu_pkg::OR, cpu_pkg::XOR};
        start_program();
        for (int r = 1; r <= 5; r++) begin
            emit_const(r, $urandom);
        end
        emit(enc_i(cpu_pkg::ADDI, 7, 0, 16'd128));
        for (int k = 0; k < 15; k++) begin
            ra = 1 + ($urandom % 5);
            rb = 1 + ($urandom % 5);
            rd = (k % 3 == 0) ? ra : 6;
            emit(enc_r(ops[k % 5], rd, ra, rb));
            emit_store_next(rd);
        end
        emit(enc_r(cpu_pkg::HALT, 0, 0, 0));
    endtask

    task automatic build_imm_program();
        start_program();
        emit(enc_i(cpu_pkg::ADDI, 7, 0, 16'd128));
        emit(enc_i(cpu_pkg::ADDI, 1, 0, 16'hffff));
        emit_store_next(1);
        emit(enc_i(cpu_pkg::ADDI, 2, 0, 16'h8000));
        emit_store_next(2);
        emit(enc_i(cpu_pkg::ADDI, 3, 1, 16'hfffb));
        emit_store_next(3);
        emit(enc_i(cpu_pkg::ADDI, 4, 0, 16'h7fff));
        emit_store_next(4);
        for (int k = 0; k < 4; k++) begin
            emit_const(5, $urandom | {16'h0000, k[0], 15'h0000});
            emit_store_next(5);
        end
        emit(enc_r(cpu_pkg::HALT, 0, 0, 0));
    endtask

    task automatic build_load_store_program();
        start_program();
        for (int k = 0; k < 4; k++) begin
            emit_const(1, $urandom);
            emit(enc_i(cpu_pkg::ADDI, 2, 0, 16'(160 + 3 * k)));
            emit(enc_r(cpu_pkg::ST, 0, 1, 2));
            emit(enc_r(cpu_pkg::LD, 3, 2, 0));
            emit(enc_i(cpu_pkg::ADDI, 4, 0, 16'(200 + k)));
            emit(enc_r(cpu_pkg::ST, 0, 3, 4));
        end
        emit(enc_r(cpu_pkg::HALT, 0, 0, 0));
    endtask

    task automatic build_branch_program();
        int count;
        int skip_pos;
        int loop_pos;
        int exit_pos;
        count = 3 + ($urandom % 4);
        start_program();
        emit(enc_i(cpu_pkg::ADDI, 7, 0, 16'd128));
        // r5 is untouched since reset, so this jumps over the store
        skip_pos = prog_len;
        emit(enc_i(cpu_pkg::BZ, 0, 5, 16'd0));
        emit(enc_r(cpu_pkg::ST, 0, 7, 7));
        img[skip_pos] = enc_i(cpu_pkg::BZ, 0, 5, 16'(prog_len));
        // Nonzero r6 must fall through to its store
        emit(enc_i(cpu_pkg::ADDI, 6, 0, 16'd9));
        emit(enc_i(cpu_pkg::BZ, 0, 6, 16'(prog_len + 2)));
        emit_store_next(6);
        emit(enc_i(cpu_pkg::ADDI, 2, 0, 16'd1));
        emit(enc_i(cpu_pkg::ADDI, 1, 0, 16'(count)));
        loop_pos = prog_len;
        emit_store_next(1);
        emit(enc_r(cpu_pkg::SUB, 1, 1, 2));
        exit_pos = prog_len;
        emit(enc_i(cpu_pkg::BZ, 0, 1, 16'd0));
        emit(enc_i(cpu_pkg::BZ, 0, 0, 16'(loop_pos)));
        img[exit_pos] = enc_i(cpu_pkg::BZ, 0, 1, 16'(prog_len));
        emit_store_next(1);
        emit(enc_r(cpu_pkg::HALT, 0, 0, 0));
    endtask

    initial begin
        void'($urandom(32'hc5f3430b));
        clock = 1'b0;
        rst_n = 1'b0;
        store_count = 0;
        test_name = "startup";
        start_program();
        for (int i = 0; i < 256; i++) begin
            mem[i] <= img[i];
        end
        build_regreg_program();
        run_test("register_ops");
        build_imm_program();
        run_test("immediates");
        build_load_store_program();
        run_test("load_store");
        for (int k = 0; k < 4; k++) begin
            check_value("load_store copy", exp_data[2 * k], mem[200 + k]);
        end
        build_branch_program();
        run_test("branch_loop");
        start_program();
        emit(enc_r(cpu_pkg::HALT, 0, 0, 0));
        run_test("halt_only");
        $display("PASS: all tests");
        $finish;
    end

endmodule
